// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] index26_t;

    // primary opcodes.
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;
    localparam opcode_t OP_ADDIU   = 6'h09;

    // function codes under OP_SPECIAL.
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_JALR = 6'h09;

    // rt field codes under OP_REGIMM.
    localparam reg_idx_t RT_BLTZ   = 5'h00;
    localparam reg_idx_t RT_BGEZ   = 5'h01;
    localparam reg_idx_t RT_BLTZAL = 5'h10;
    localparam reg_idx_t RT_BGEZAL = 5'h11;

    localparam reg_idx_t LINK_REG = 5'd31;

    typedef enum logic [3:0] {
        CTRL_NOP,
        CTRL_ADDIU,
        CTRL_J,
        CTRL_JAL,
        CTRL_JR,
        CTRL_JALR,
        CTRL_BEQ,
        CTRL_BNE,
        CTRL_BGEZ,
        CTRL_BGEZAL,
        CTRL_BGTZ,
        CTRL_BLEZ,
        CTRL_BLTZ,
        CTRL_BLTZAL
    } ctrl_op_e;

    typedef enum logic [1:0] {
        PH_FETCH,
        PH_EXEC1,
        PH_EXEC2
    } phase_e;

    typedef struct packed {
        ctrl_op_e op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        imm16_t   imm16;
        index26_t index26;
    } decoded_t;

    // one entry per retired instruction.
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        word_t    instr;
        logic     wr_en;
        reg_idx_t wr_idx;
        word_t    wr_data;
        addr_t    next_pc;
    } retire_t;

endpackage

`default_nettype wire

// File: verilog/axil_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module axil_fetch (
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            fetch_req,
    input  mips_pkg::addr_t      fetch_addr,
    output logic                 arvalid,
    input  wire logic            arready,
    output mips_pkg::addr_t      araddr,
    input  wire logic            rvalid,
    output logic                 rready,
    input  mips_pkg::word_t      rdata,
    output logic                 fetch_done,
    output mips_pkg::word_t      instr
);

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_ADDR,
        FS_DATA
    } fetch_state_e;

    fetch_state_e state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FS_IDLE;
        end else begin
            case (state)
                FS_IDLE: if (fetch_req) state <= FS_ADDR;
                FS_ADDR: if (arready) state <= FS_DATA;
                FS_DATA: if (rvalid) state <= FS_IDLE;
                default: state <= FS_IDLE;
            endcase
        end
    end

    // address is captured with the request and held through the handshake.
    always_ff @(posedge clk) begin
        if (state == FS_IDLE && fetch_req) begin
            araddr <= fetch_addr;
        end
        if (fetch_done) begin
            instr <= rdata;
        end
    end

    assign arvalid    = (state == FS_ADDR);
    assign rready     = (state == FS_DATA);
    assign fetch_done = rready && rvalid;

endmodule

`default_nettype wire

// File: verilog/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
    input  mips_pkg::word_t    instr,
    output mips_pkg::decoded_t dec
);

    mips_pkg::opcode_t opcode;
    mips_pkg::funct_t  funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        dec.rs      = instr[25:21];
        dec.rt      = instr[20:16];
        dec.rd      = instr[15:11];
        dec.imm16   = instr[15:0];
        dec.index26 = instr[25:0];
        dec.op      = mips_pkg::CTRL_NOP;

        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                case (funct)
                    mips_pkg::FN_JR:   dec.op = mips_pkg::CTRL_JR;
                    mips_pkg::FN_JALR: dec.op = mips_pkg::CTRL_JALR;
                    default:           dec.op = mips_pkg::CTRL_NOP;
                endcase
            end
            // branch kind sits in the rt field here.
            mips_pkg::OP_REGIMM: begin
                case (instr[20:16])
                    mips_pkg::RT_BLTZ:   dec.op = mips_pkg::CTRL_BLTZ;
                    mips_pkg::RT_BGEZ:   dec.op = mips_pkg::CTRL_BGEZ;
                    mips_pkg::RT_BLTZAL: dec.op = mips_pkg::CTRL_BLTZAL;
                    mips_pkg::RT_BGEZAL: dec.op = mips_pkg::CTRL_BGEZAL;
                    default:             dec.op = mips_pkg::CTRL_NOP;
                endcase
            end
            mips_pkg::OP_J:     dec.op = mips_pkg::CTRL_J;
            mips_pkg::OP_JAL:   dec.op = mips_pkg::CTRL_JAL;
            mips_pkg::OP_BEQ:   dec.op = mips_pkg::CTRL_BEQ;
            mips_pkg::OP_BNE:   dec.op = mips_pkg::CTRL_BNE;
            mips_pkg::OP_BLEZ:  dec.op = mips_pkg::CTRL_BLEZ;
            mips_pkg::OP_BGTZ:  dec.op = mips_pkg::CTRL_BGTZ;
            mips_pkg::OP_ADDIU: dec.op = mips_pkg::CTRL_ADDIU;
            default:            dec.op = mips_pkg::CTRL_NOP;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire logic          clk,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    input  wire logic          wr_en,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // entry 0 may get written but is never seen.
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

`default_nettype wire

// File: verilog/next_instruction.sv
`timescale 1ns/100ps
`default_nettype none

module next_instruction (
    input  wire logic          clk,
    input  wire logic          arst_n,
    output logic               fetch_req,
    output mips_pkg::addr_t    pc,
    input  wire logic          fetch_done,
    input  mips_pkg::word_t    instr,
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    output logic               wr_en,
    output mips_pkg::reg_idx_t wr_idx,
    output mips_pkg::word_t    wr_data,
    output mips_pkg::retire_t  retire
);

    mips_pkg::phase_e phase;
    logic             booted;
    logic             exec2;
    logic             taken;
    logic             link_en;
    mips_pkg::word_t  rs_q;
    mips_pkg::word_t  rt_q;
    mips_pkg::word_t  imm_sext;
    mips_pkg::addr_t  pc_plus4;
    mips_pkg::addr_t  branch_target;
    mips_pkg::addr_t  jump_target;
    mips_pkg::addr_t  next_pc;

    assign exec2         = (phase == mips_pkg::PH_EXEC2);
    assign imm_sext      = {{16{dec.imm16[15]}}, dec.imm16};
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], dec.index26, 2'b00};

    // branch conditions compare as signed words.
    always_comb begin
        case (dec.op)
            mips_pkg::CTRL_BEQ:    taken = (rs_q == rt_q);
            mips_pkg::CTRL_BNE:    taken = (rs_q != rt_q);
            mips_pkg::CTRL_BGEZ,
            mips_pkg::CTRL_BGEZAL: taken = ($signed(rs_q) >= 0);
            mips_pkg::CTRL_BGTZ:   taken = ($signed(rs_q) > 0);
            mips_pkg::CTRL_BLEZ:   taken = ($signed(rs_q) <= 0);
            mips_pkg::CTRL_BLTZ,
            mips_pkg::CTRL_BLTZAL: taken = ($signed(rs_q) < 0);
            default:               taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.op)
            mips_pkg::CTRL_J,
            mips_pkg::CTRL_JAL:  next_pc = jump_target;
            mips_pkg::CTRL_JR,
            mips_pkg::CTRL_JALR: next_pc = {rs_q[31:2], 2'b00};
            default:             next_pc = taken ? branch_target : pc_plus4;
        endcase
    end

    // link writes happen whether or not the branch is taken.
    always_comb begin
        link_en = 1'b1;
        wr_idx  = mips_pkg::LINK_REG;
        wr_data = pc_plus4;
        case (dec.op)
            mips_pkg::CTRL_JAL,
            mips_pkg::CTRL_BGEZAL,
            mips_pkg::CTRL_BLTZAL: wr_idx = mips_pkg::LINK_REG;
            mips_pkg::CTRL_JALR:   wr_idx = dec.rd;
            mips_pkg::CTRL_ADDIU: begin
                wr_idx  = dec.rt;
                wr_data = rs_q + imm_sext;
            end
            default: link_en = 1'b0;
        endcase
    end

    assign wr_en = exec2 && link_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= mips_pkg::PH_FETCH;
            pc        <= '0;
            booted    <= 1'b0;
            fetch_req <= 1'b0;
            retire    <= '0;
        end else begin
            booted    <= 1'b1;
            fetch_req <= !booted || exec2;
            case (phase)
                mips_pkg::PH_FETCH: if (fetch_done) phase <= mips_pkg::PH_EXEC1;
                mips_pkg::PH_EXEC1: phase <= mips_pkg::PH_EXEC2;
                default: begin
                    phase <= mips_pkg::PH_FETCH;
                    pc    <= next_pc;
                end
            endcase
            retire.valid <= exec2;
            if (exec2) begin
                retire.pc      <= pc;
                retire.instr   <= instr;
                retire.wr_en   <= wr_en;
                retire.wr_idx  <= wr_idx;
                retire.wr_data <= wr_data;
                retire.next_pc <= next_pc;
            end
        end
    end

    // operands are sampled at the end of exec1.
    always_ff @(posedge clk) begin
        if (phase == mips_pkg::PH_EXEC1) begin
            rs_q <= rs_data;
            rt_q <= rt_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core (
    input  wire logic          clk,
    input  wire logic          arst_n,
    output logic               arvalid,
    input  wire logic          arready,
    output mips_pkg::addr_t    araddr,
    input  wire logic          rvalid,
    output logic               rready,
    input  mips_pkg::word_t    rdata,
    output mips_pkg::retire_t  retire
);

    logic               fetch_req;
    logic               fetch_done;
    mips_pkg::addr_t    pc;
    mips_pkg::word_t    instr;
    mips_pkg::decoded_t dec;
    mips_pkg::word_t    rs_data;
    mips_pkg::word_t    rt_data;
    logic               wr_en;
    mips_pkg::reg_idx_t wr_idx;
    mips_pkg::word_t    wr_data;

    axil_fetch u_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (pc),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .fetch_done (fetch_done),
        .instr      (instr)
    );

    instr_decode u_decode (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_regs (
        .clk     (clk),
        .rs_idx  (dec.rs),
        .rt_idx  (dec.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    next_instruction u_next (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .pc         (pc),
        .fetch_done (fetch_done),
        .instr      (instr),
        .dec        (dec),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .retire     (retire)
    );

endmodule

`default_nettype wire

// File: verification/tb_mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core;

    localparam int NUM_INSTR      = 2000;
    // worst case per instruction is 4 core cycles, 6 memory wait cycles and 2 spare.
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 + 100;
    localparam logic [31:0] SEED  = 32'h7b2b5015;

    logic              clk;
    logic              arst_n;
    logic              arvalid;
    logic              arready;
    mips_pkg::addr_t   araddr;
    logic              rvalid;
    logic              rready;
    mips_pkg::word_t   rdata;
    mips_pkg::retire_t retire;

    logic [31:0]       lfsr;
    mips_pkg::word_t   mem [256];
    mips_pkg::word_t   model_regs [32];
    mips_pkg::addr_t   model_pc;
    int                retire_count = 0;
    int                fetch_count = 0;
    int                cycle_count = 0;

    mips_core uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .retire  (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr with taps 32, 22, 2 and 1 stepped once per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // registers 0 to 6 and the link register.
    function automatic mips_pkg::reg_idx_t pick_reg();
        logic [31:0] v;
        v = rand_bits(3);
        return (v[2:0] == 3'd7) ? mips_pkg::LINK_REG : {2'b00, v[2:0]};
    endfunction

    task automatic build_program();
        logic [31:0]        sel;
        logic [31:0]        r;
        logic [15:0]        imm;
        logic [15:0]        off;
        mips_pkg::reg_idx_t rs;
        mips_pkg::reg_idx_t rt;
        mips_pkg::reg_idx_t rd;
        for (int i = 0; i < 256; i++) begin
            sel = rand_bits(5) % 18;
            rs  = pick_reg();
            rt  = pick_reg();
            rd  = pick_reg();
            r   = rand_bits(8);
            imm = {{12{r[3]}}, r[3:0]};
            off = {{10{r[5]}}, r[5:0]};
            case (sel)
                6:  mem[8'(i)] = {mips_pkg::OP_J, 18'd0, r[7:0]};
                7:  mem[8'(i)] = {mips_pkg::OP_JAL, 18'd0, r[7:0]};
                8:  mem[8'(i)] = {mips_pkg::OP_SPECIAL, rs, 15'd0, mips_pkg::FN_JR};
                9:  mem[8'(i)] = {mips_pkg::OP_SPECIAL, rs, 5'd0, rd, 5'd0, mips_pkg::FN_JALR};
                10: mem[8'(i)] = {mips_pkg::OP_BEQ, rs, rt, off};
                11: mem[8'(i)] = {mips_pkg::OP_BNE, rs, rt, off};
                12: mem[8'(i)] = {mips_pkg::OP_BLEZ, rs, 5'd0, off};
                13: mem[8'(i)] = {mips_pkg::OP_BGTZ, rs, 5'd0, off};
                14: mem[8'(i)] = {mips_pkg::OP_REGIMM, rs, mips_pkg::RT_BLTZ, off};
                15: mem[8'(i)] = {mips_pkg::OP_REGIMM, rs, mips_pkg::RT_BGEZ, off};
                16: mem[8'(i)] = {mips_pkg::OP_REGIMM, rs, mips_pkg::RT_BLTZAL, off};
                17: mem[8'(i)] = {mips_pkg::OP_REGIMM, rs, mips_pkg::RT_BGEZAL, off};
                default: mem[8'(i)] = {mips_pkg::OP_ADDIU, rs, rt, imm};
            endcase
        end
    endtask

    task automatic step_model();
        mips_pkg::word_t    w;
        mips_pkg::word_t    a;
        mips_pkg::word_t    b;
        mips_pkg::word_t    sext;
        mips_pkg::word_t    data;
        mips_pkg::addr_t    pc4;
        mips_pkg::addr_t    npc;
        mips_pkg::reg_idx_t idx;
        logic               en;
        logic               taken;
        w     = mem[model_pc[9:2]];
        a     = model_regs[w[25:21]];
        b     = model_regs[w[20:16]];
        sext  = {{16{w[15]}}, w[15:0]};
        pc4   = model_pc + 32'd4;
        npc   = pc4;
        data  = pc4;
        idx   = mips_pkg::LINK_REG;
        en    = 1'b0;
        taken = 1'b0;
        case (w[31:26])
            mips_pkg::OP_SPECIAL: begin
                if (w[5:0] == mips_pkg::FN_JR || w[5:0] == mips_pkg::FN_JALR) begin
                    npc = {a[31:2], 2'b00};
                end
                en  = (w[5:0] == mips_pkg::FN_JALR);
                idx = w[15:11];
            end
            mips_pkg::OP_REGIMM: begin
                case (w[20:16])
                    mips_pkg::RT_BLTZ, mips_pkg::RT_BLTZAL: taken = a[31];
                    mips_pkg::RT_BGEZ, mips_pkg::RT_BGEZAL: taken = !a[31];
                    default: taken = 1'b0;
                endcase
                en = (w[20:16] == mips_pkg::RT_BLTZAL) || (w[20:16] == mips_pkg::RT_BGEZAL);
            end
            mips_pkg::OP_J: npc = {pc4[31:28], w[25:0], 2'b00};
            mips_pkg::OP_JAL: begin
                npc = {pc4[31:28], w[25:0], 2'b00};
                en  = 1'b1;
            end
            mips_pkg::OP_BEQ:  taken = (a == b);
            mips_pkg::OP_BNE:  taken = (a != b);
            mips_pkg::OP_BLEZ: taken = a[31] || (a == '0);
            mips_pkg::OP_BGTZ: taken = !a[31] && (a != '0);
            mips_pkg::OP_ADDIU: begin
                en   = 1'b1;
                idx  = w[20:16];
                data = a + sext;
            end
            default: taken = 1'b0;
        endcase
        if (taken) begin
            npc = pc4 + {sext[29:0], 2'b00};
        end
        check_value(retire.pc, model_pc, "retire pc");
        check_value(retire.instr, w, "retire instr");
        check_value(fetch_count, retire_count + 1, "fetches at retire");
        check_value(32'(retire.wr_en), 32'(en), "retire wr_en");
        if (en) begin
            check_value(32'(retire.wr_idx), 32'(idx), "retire wr_idx");
            check_value(retire.wr_data, data, "retire wr_data");
            // register 0 stays zero.
            if (idx != '0) begin
                model_regs[idx] = data;
            end
        end
        check_value(retire.next_pc, npc, "retire next_pc");
        model_pc = npc;
        retire_count++;
    endtask

    always @(negedge clk) begin
        if (arst_n && retire.valid) begin
            step_model();
        end
    end

    // memory side of the read bus waits a random time on both channels.
    initial begin
        mips_pkg::addr_t addr;
        logic [31:0]     delay;
        @(posedge arst_n);
        forever begin
            @(negedge clk);
            if (arvalid) begin
                addr = araddr;
                check_value(addr, model_pc, "araddr");
                fetch_count++;
                delay = rand_bits(2);
                repeat (delay) begin
                    @(negedge clk);
                    check_value(32'(arvalid), 32'd1, "arvalid held");
                    check_value(araddr, addr, "araddr held");
                end
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                delay = rand_bits(2);
                repeat (delay) @(negedge clk);
                check_value(32'(rready), 32'd1, "rready");
                rvalid = 1'b1;
                rdata  = mem[addr[9:2]];
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: only %0d instructions retired in %0d cycles",
                     retire_count, TIMEOUT_CYCLES);
            $display("test failed");
            $fatal(1);
        end
    end

    initial begin
        lfsr     = SEED;
        arst_n   = 1'b0;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;
        model_pc = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[5'(i)] = '0;
        end
        build_program();
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        while (retire_count < NUM_INSTR) @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
verilog/mips_pkg.sv
verilog/axil_fetch.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/next_instruction.sv
verilog/mips_core.sv
verification/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing -f src.f --top-module tb_mips_core -o tb_mips_core

# the simulator may exit nonzero on failure; the log decides.
./obj_dir/tb_mips_core > sim.log 2>&1 || true
cat sim.log

grep -qx "test passed" sim.log
